//--- logic/csr_file.sv
`timescale 1ns/1ps
`default_nettype none

module csr_file
    import pipeline_pkg::*;
    import csr_pkg::*;
#(
    parameter bus32_t TID_RESET = 32'h0000_0a5c
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       csr_read_en,
    input  csr_addr_t  csr_read_addr,
    output bus32_t     csr_read_data,
    input  csr_write_t csr_write,
    output bus64_t     cnt
);

    bus32_t crmd;
    bus32_t prmd;
    bus32_t era;
    bus32_t save [4];
    bus32_t tid;
    bus64_t stable_cnt;

    // a write replaces the whole register; unknown addresses are dropped.
    always_ff @(posedge clk) begin
        if (reset) begin
            crmd    <= '0;
            prmd    <= '0;
            era     <= '0;
            save[0] <= '0;
            save[1] <= '0;
            save[2] <= '0;
            save[3] <= '0;
            tid     <= TID_RESET;
        end
        else if (csr_write.csr_write_en) begin
            case (csr_write.csr_write_addr)
                CSR_CRMD:  crmd    <= csr_write.csr_write_data;
                CSR_PRMD:  prmd    <= csr_write.csr_write_data;
                CSR_ERA:   era     <= csr_write.csr_write_data;
                CSR_SAVE0: save[0] <= csr_write.csr_write_data;
                CSR_SAVE1: save[1] <= csr_write.csr_write_data;
                CSR_SAVE2: save[2] <= csr_write.csr_write_data;
                CSR_SAVE3: save[3] <= csr_write.csr_write_data;
                CSR_TID:   tid     <= csr_write.csr_write_data;
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            stable_cnt <= '0;
        end
        else begin
            stable_cnt <= stable_cnt + 64'd1; // free running.
        end
    end

    assign cnt = stable_cnt;

    always_comb begin
        csr_read_data = 32'b0;
        if (csr_read_en) begin
            case (csr_read_addr)
                CSR_CRMD:  csr_read_data = crmd;
                CSR_PRMD:  csr_read_data = prmd;
                CSR_ERA:   csr_read_data = era;
                CSR_SAVE0: csr_read_data = save[0];
                CSR_SAVE1: csr_read_data = save[1];
                CSR_SAVE2: csr_read_data = save[2];
                CSR_SAVE3: csr_read_data = save[3];
                CSR_TID:   csr_read_data = tid;
                default:   csr_read_data = 32'b0;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/csr_pkg.sv
`default_nettype none

package csr_pkg;

    localparam int CSR_ADDR_W = 14;
    localparam int CSR_DATA_W = 32;

    typedef logic [CSR_ADDR_W-1:0] csr_addr_t;

    localparam csr_addr_t CSR_CRMD  = 14'h0000;
    localparam csr_addr_t CSR_PRMD  = 14'h0001;
    localparam csr_addr_t CSR_ERA   = 14'h0006;
    localparam csr_addr_t CSR_SAVE0 = 14'h0030;
    localparam csr_addr_t CSR_SAVE1 = 14'h0031;
    localparam csr_addr_t CSR_SAVE2 = 14'h0032;
    localparam csr_addr_t CSR_SAVE3 = 14'h0033;
    localparam csr_addr_t CSR_TID   = 14'h0040;

    // the same struct serves as the writeback write port and the forward path.
    typedef struct packed {
        logic                  csr_write_en;
        csr_addr_t             csr_write_addr;
        logic [CSR_DATA_W-1:0] csr_write_data;
        logic                  is_llw_scw;
    } csr_write_t;

endpackage

`default_nettype wire

//--- logic/data_ram.sv
`timescale 1ns/1ps
`default_nettype none

module data_ram
    import pipeline_pkg::*;
#(
    parameter int RAM_WORDS   = 256,
    parameter int MISS_CYCLES = 3
) (
    input  logic    clk,
    input  logic    reset,
    input  ex_mem_t ex_mem,
    output bus32_t  rdata,
    output logic    data_ok,
    output logic    cache_miss
);

    localparam int IDX_W  = $clog2(RAM_WORDS);
    localparam int MISS_W = $clog2(MISS_CYCLES + 1);

    function automatic bus32_t word_pattern(input int unsigned i);
        logic [7:0] b;
        b = 8'(i);
        return {b ^ 8'h5a, b, ~b, b + 8'h81};
    endfunction

    bus32_t rom [RAM_WORDS];

    for (genvar g = 0; g < RAM_WORDS; g++) begin : g_rom
        assign rom[g] = word_pattern(g);
    end

    logic              line_valid;
    logic [27:0]       line_tag;
    logic [MISS_W-1:0] miss_count;
    logic              is_load;
    logic              hit;

    assign is_load    = is_load_op(ex_mem.aluop);
    assign hit        = line_valid && (line_tag == ex_mem.mem_addr[31:4]);
    assign rdata      = rom[ex_mem.mem_addr[IDX_W+1:2]];
    assign data_ok    = is_load && hit;
    assign cache_miss = is_load && !hit;

    // the line becomes valid after the last miss cycle, so the next cycle hits.
    always_ff @(posedge clk) begin
        if (reset) begin
            line_valid <= 1'b0;
            miss_count <= '0;
        end
        else if (cache_miss) begin
            if (miss_count == MISS_W'(MISS_CYCLES - 1)) begin
                line_valid <= 1'b1;
                miss_count <= '0;
            end
            else begin
                miss_count <= miss_count + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cache_miss && (miss_count == MISS_W'(MISS_CYCLES - 1))) begin
            line_tag <= ex_mem.mem_addr[31:4];
        end
    end

endmodule

`default_nettype wire

//--- logic/mem_access.sv
`timescale 1ns/1ps
`default_nettype none

module mem_access
    import pipeline_pkg::*;
    import csr_pkg::*;
(
    input  ex_mem_t    ex_mem,

    input  bus32_t     rdata,
    input  logic       data_ok,
    input  logic       cache_miss,

    output logic       csr_read_en,
    output csr_addr_t  csr_read_addr,
    input  bus32_t     csr_read_data,
    input  csr_write_t wb_forward,

    input  bus64_t     cnt,

    output logic       pause,
    output mem_wb_t    mem_wb_next,
    output mem_ctrl_t  mem_ctrl
);

    logic       load_hit;
    logic [1:0] offset;
    bus32_t     shifted;
    logic [7:0] byte_sel;
    logic [15:0] half_sel;
    logic       half_ok;
    bus32_t     load_data;
    bus32_t     csr_value;

    // RDCNTID reads TID through the normal CSR port.
    assign csr_read_en   = (ex_mem.aluop == ALU_RDCNTID) ? 1'b1 : ex_mem.csr_read_en;
    assign csr_read_addr = (ex_mem.aluop == ALU_RDCNTID) ? CSR_TID : ex_mem.csr_addr;

    assign load_hit = data_ok && !cache_miss;
    assign offset   = ex_mem.mem_addr[1:0];
    assign shifted  = rdata >> {offset, 3'b000};
    assign byte_sel = shifted[7:0];
    assign half_sel = offset[1] ? rdata[31:16] : rdata[15:0];
    assign half_ok  = !offset[0]; // odd halfword offsets give zero.

    always_comb begin
        case (ex_mem.aluop)
            ALU_LDB:  load_data = {{24{byte_sel[7]}}, byte_sel};
            ALU_LDBU: load_data = {24'b0, byte_sel};
            ALU_LDH:  load_data = half_ok ? {{16{half_sel[15]}}, half_sel} : 32'b0;
            ALU_LDHU: load_data = half_ok ? {16'b0, half_sel} : 32'b0;
            ALU_LDW,
            ALU_LLW:  load_data = rdata;
            default:  load_data = 32'b0;
        endcase
    end

    // a CSR write sitting in writeback has not reached the file yet.
    always_comb begin
        if (csr_read_en && wb_forward.csr_write_en &&
            (csr_read_addr == wb_forward.csr_write_addr)) begin
            csr_value = wb_forward.csr_write_data;
        end
        else if (csr_read_en) begin
            csr_value = csr_read_data;
        end
        else begin
            csr_value = 32'b0;
        end
    end

    always_comb begin
        pause = 1'b0;

        mem_wb_next.data_write.write_en   = ex_mem.reg_write_en;
        mem_wb_next.data_write.write_addr = ex_mem.reg_write_addr;
        mem_wb_next.data_write.write_data = ex_mem.reg_write_data;

        mem_wb_next.csr_write.csr_write_en   = ex_mem.csr_write_en;
        mem_wb_next.csr_write.csr_write_addr = ex_mem.csr_addr;
        mem_wb_next.csr_write.csr_write_data = ex_mem.csr_write_data;
        mem_wb_next.csr_write.is_llw_scw     = ex_mem.is_llw_scw;

        if (is_load_op(ex_mem.aluop)) begin
            pause = !load_hit; // held until the cache returns the line.
            mem_wb_next.data_write.write_data = load_data;
        end

        case (ex_mem.aluop)
            ALU_CSRRD,
            ALU_CSRWR,
            ALU_RDCNTID: begin
                mem_wb_next.data_write.write_data = csr_value;
            end
            ALU_CSRXCHG: begin
                mem_wb_next.data_write.write_data = csr_value;
                mem_wb_next.csr_write.csr_write_data =
                    (csr_value & ~ex_mem.csr_mask) | (ex_mem.csr_write_data & ex_mem.csr_mask);
            end
            ALU_RDCNTVLW: begin
                mem_wb_next.data_write.write_data = cnt[31:0];
            end
            ALU_RDCNTVHW: begin
                mem_wb_next.data_write.write_data = cnt[63:32];
            end
            default: begin
            end
        endcase
    end

    always_comb begin
        mem_ctrl.pc               = ex_mem.pc;
        mem_ctrl.exception_addr   = ex_mem.mem_addr;
        mem_ctrl.is_exception     = ex_mem.is_exception;
        mem_ctrl.exception_cause  = ex_mem.exception_cause;
        // an ERTN that carries an exception is handled as the exception.
        mem_ctrl.is_ertn          = (ex_mem.is_exception == 6'b0) && (ex_mem.aluop == ALU_ERTN);
        mem_ctrl.is_idle          = (ex_mem.aluop == ALU_IDLE);
        mem_ctrl.is_syscall_break = (ex_mem.aluop == ALU_SYSCALL) ||
                                    (ex_mem.aluop == ALU_BREAK);
    end

endmodule

`default_nettype wire

//--- logic/mem_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem
    import pipeline_pkg::*;
    import csr_pkg::*;
#(
    parameter int     RAM_WORDS   = 256,
    parameter int     MISS_CYCLES = 3,
    parameter bus32_t TID_RESET   = 32'h0000_0a5c
) (
    input  logic       clk,
    input  logic       reset,
    input  ex_mem_t    ex_in,
    output logic       pause,
    output reg_write_t wb_write,
    output mem_ctrl_t  mem_ctrl
);

    ex_mem_t    ex_mem;
    bus32_t     rdata;
    logic       data_ok;
    logic       cache_miss;
    logic       csr_read_en;
    csr_addr_t  csr_read_addr;
    bus32_t     csr_read_data;
    bus64_t     cnt;
    mem_wb_t    mem_wb_next;
    mem_wb_t    mem_wb;

    stage_reg #(.payload_t(ex_mem_t)) u_ex_mem (
        .clk   (clk),
        .reset (reset),
        .stall (pause),
        .flush (1'b0),
        .d     (ex_in),
        .q     (ex_mem)
    );

    data_ram #(.RAM_WORDS(RAM_WORDS), .MISS_CYCLES(MISS_CYCLES)) u_data_ram (
        .clk        (clk),
        .reset      (reset),
        .ex_mem     (ex_mem),
        .rdata      (rdata),
        .data_ok    (data_ok),
        .cache_miss (cache_miss)
    );

    mem_access u_mem_access (
        .ex_mem        (ex_mem),
        .rdata         (rdata),
        .data_ok       (data_ok),
        .cache_miss    (cache_miss),
        .csr_read_en   (csr_read_en),
        .csr_read_addr (csr_read_addr),
        .csr_read_data (csr_read_data),
        .wb_forward    (mem_wb.csr_write),
        .cnt           (cnt),
        .pause         (pause),
        .mem_wb_next   (mem_wb_next),
        .mem_ctrl      (mem_ctrl)
    );

    csr_file #(.TID_RESET(TID_RESET)) u_csr_file (
        .clk           (clk),
        .reset         (reset),
        .csr_read_en   (csr_read_en),
        .csr_read_addr (csr_read_addr),
        .csr_read_data (csr_read_data),
        .csr_write     (mem_wb.csr_write),
        .cnt           (cnt)
    );

    // a paused load leaves a bubble in writeback.
    stage_reg #(.payload_t(mem_wb_t)) u_mem_wb (
        .clk   (clk),
        .reset (reset),
        .stall (1'b0),
        .flush (pause),
        .d     (mem_wb_next),
        .q     (mem_wb)
    );

    assign wb_write = mem_wb.data_write;

endmodule

`default_nettype wire

//--- logic/pipeline_pkg.sv
`default_nettype none

package pipeline_pkg;

    import csr_pkg::*;

    typedef logic [31:0] bus32_t;
    typedef logic [63:0] bus64_t;

    // ALU_NOP must stay zero so that a cleared stage register is a bubble.
    typedef enum logic [4:0] {
        ALU_NOP,
        ALU_LDB,
        ALU_LDBU,
        ALU_LDH,
        ALU_LDHU,
        ALU_LDW,
        ALU_LLW,
        ALU_CSRRD,
        ALU_CSRWR,
        ALU_CSRXCHG,
        ALU_RDCNTID,
        ALU_RDCNTVLW,
        ALU_RDCNTVHW,
        ALU_ERTN,
        ALU_SYSCALL,
        ALU_BREAK,
        ALU_IDLE
    } aluop_t;

    typedef struct packed {
        bus32_t      pc;
        aluop_t      aluop;
        bus32_t      mem_addr;
        logic        reg_write_en;
        logic [4:0]  reg_write_addr;
        bus32_t      reg_write_data;
        logic        csr_read_en;
        logic        csr_write_en;
        csr_addr_t   csr_addr;
        bus32_t      csr_write_data;
        bus32_t      csr_mask;
        logic        is_llw_scw;
        logic [5:0]  is_exception;
        logic [5:0]  exception_cause;
    } ex_mem_t;

    typedef struct packed {
        logic       write_en;
        logic [4:0] write_addr;
        bus32_t     write_data;
    } reg_write_t;

    typedef struct packed {
        reg_write_t data_write;
        csr_write_t csr_write;
    } mem_wb_t;

    typedef struct packed {
        bus32_t     pc;
        bus32_t     exception_addr;
        logic [5:0] is_exception;
        logic [5:0] exception_cause;
        logic       is_ertn;
        logic       is_idle;
        logic       is_syscall_break;
    } mem_ctrl_t;

    function automatic logic is_load_op(input aluop_t op);
        return op inside {ALU_LDB, ALU_LDBU, ALU_LDH, ALU_LDHU, ALU_LDW, ALU_LLW};
    endfunction

endpackage

`default_nettype wire

//--- logic/stage_reg.sv
`timescale 1ns/1ps
`default_nettype none

module stage_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     stall,
    input  logic     flush,
    input  payload_t d,
    output payload_t q
);

    // flush is checked before stall, so a stalled stage can still be emptied.
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            q <= '0;
        end
        else if (!stall) begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

//--- mem_stage.f
logic/csr_pkg.sv
logic/pipeline_pkg.sv
logic/stage_reg.sv
logic/mem_access.sv
logic/csr_file.sv
logic/data_ram.sv
logic/mem_subsystem.sv
verification/mem_stage_props.sv
verification/mem_stage_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the memory stage testbench with Verilator, runs it and checks the log.
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module mem_stage_tb \
    -f mem_stage.f -o mem_stage_sim \
    && ./obj_dir/mem_stage_sim > sim.log 2>&1

grep -q "all tests passed" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

//--- verification/mem_stage_props.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage_props
    import pipeline_pkg::*;
#(
    parameter int MISS_CYCLES = 3
) (
    input logic       clk,
    input logic       reset,
    input logic       pause,
    input ex_mem_t    ex_mem,
    input reg_write_t wb_write,
    input mem_ctrl_t  mem_ctrl
);

    int unsigned fail_count = 0; // number of failed assertions, read by the testbench.

    // a paused load leaves a bubble, so the next cycle carries no register write.
    bubble_after_pause: assert property (
        @(posedge clk) disable iff (reset) pause |=> !wb_write.write_en
    ) else begin
        fail_count++;
        $error("register write reached writeback right after a pause");
    end

    only_loads_pause: assert property (
        @(posedge clk) disable iff (reset) pause |-> is_load_op(ex_mem.aluop)
    ) else begin
        fail_count++;
        $error("pause raised for an op that is not a load");
    end

    quiet_after_reset: assert property (
        @(posedge clk) $fell(reset) |-> !pause && !wb_write.write_en &&
            !mem_ctrl.is_ertn && !mem_ctrl.is_idle && !mem_ctrl.is_syscall_break &&
            (mem_ctrl.is_exception == '0)
    ) else begin
        fail_count++;
        $error("control outputs not idle in the first cycle after reset");
    end

    // a line miss is over once the miss delay has run out.
    miss_window: assert property (
        @(posedge clk) disable iff (reset) $rose(pause) |-> ##MISS_CYCLES !pause
    ) else begin
        fail_count++;
        $error("pause still high when the miss delay had run out");
    end

endmodule

bind mem_subsystem mem_stage_props #(.MISS_CYCLES(MISS_CYCLES)) u_props (
    .clk      (clk),
    .reset    (reset),
    .pause    (pause),
    .ex_mem   (ex_mem),
    .wb_write (wb_write),
    .mem_ctrl (mem_ctrl)
);

`default_nettype wire

//--- verification/mem_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage_tb
    import pipeline_pkg::*;
    import csr_pkg::*;
();

    localparam int     RAM_WORDS   = 256;
    localparam int     MISS_CYCLES = 3;
    localparam bus32_t TID_RESET   = 32'h0000_0a5c;
    localparam int     WAIT_LIMIT  = 50;

    logic       clk = 1'b0;
    logic       reset;
    ex_mem_t    ex_in;
    logic       pause;
    reg_write_t wb_write;
    mem_ctrl_t  mem_ctrl;

    bus32_t     lcg_state;
    bus32_t     next_pc;
    bus64_t     cycle_cnt;
    int         stall_cycles;
    reg_write_t expect_q [$];
    bus32_t     csr_model [csr_addr_t];

    mem_subsystem #(
        .RAM_WORDS   (RAM_WORDS),
        .MISS_CYCLES (MISS_CYCLES),
        .TID_RESET   (TID_RESET)
    ) dut (
        .clk      (clk),
        .reset    (reset),
        .ex_in    (ex_in),
        .pause    (pause),
        .wb_write (wb_write),
        .mem_ctrl (mem_ctrl)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        if (reset) begin
            cycle_cnt <= '0;
        end
        else begin
            cycle_cnt <= cycle_cnt + 64'd1; // the stable counter starts from zero.
        end
    end

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    function automatic bus32_t next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // byte k of word i, counted from the low end of the word.
    function automatic logic [7:0] mem_byte(input bus32_t addr);
        logic [7:0] idx;
        idx = 8'((addr >> 2) % RAM_WORDS);
        case (addr[1:0])
            2'd0:    return idx + 8'h81;
            2'd1:    return ~idx;
            2'd2:    return idx;
            default: return idx ^ 8'h5a;
        endcase
    endfunction

    function automatic bus32_t load_expect(input aluop_t op, input bus32_t addr);
        bus32_t      base;
        logic [7:0]  b;
        logic [15:0] h;
        base = {addr[31:2], 2'b00};
        b = mem_byte(addr);
        h = {mem_byte(addr | 32'd1), mem_byte(addr)};
        case (op)
            ALU_LDB:  return {{24{b[7]}}, b};
            ALU_LDBU: return {24'h0, b};
            ALU_LDH:  return addr[0] ? 32'h0 : {{16{h[15]}}, h};
            ALU_LDHU: return addr[0] ? 32'h0 : {16'h0, h};
            default:  return {mem_byte(base + 32'd3), mem_byte(base + 32'd2),
                              mem_byte(base + 32'd1), mem_byte(base)};
        endcase
    endfunction

    function automatic ex_mem_t make_op(input aluop_t op, input bus32_t addr,
                                        input logic [4:0] rd);
        ex_mem_t e;
        e = '0;
        e.aluop          = op;
        e.mem_addr       = addr;
        e.reg_write_en   = (rd != 5'd0);
        e.reg_write_addr = rd;
        return e;
    endfunction

    function automatic ex_mem_t make_csr_op(input aluop_t op, input csr_addr_t addr,
                                            input bus32_t data, input bus32_t mask);
        ex_mem_t e;
        e = make_op(op, 32'h0, 5'd7);
        e.csr_read_en    = 1'b1;
        e.csr_write_en   = (op == ALU_CSRWR) || (op == ALU_CSRXCHG);
        e.csr_addr       = addr;
        e.csr_write_data = data;
        e.csr_mask       = mask;
        return e;
    endfunction

    // drives the op at the current falling edge and returns once it sits unpaused in the stage.
    task automatic issue_op(input ex_mem_t op, input bus32_t expect_data);
        int         waited;
        reg_write_t w;
        op.pc = next_pc;
        next_pc = next_pc + 32'd4;
        ex_in = op;
        if (op.reg_write_en) begin
            w.write_en   = 1'b1;
            w.write_addr = op.reg_write_addr;
            w.write_data = expect_data;
            expect_q.push_back(w);
        end
        @(negedge clk);
        waited = 0;
        while (pause) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                stop_with_error("pause stayed high longer than the wait limit");
            end
        end
        stall_cycles = waited;
    endtask

    task automatic check_ctrl(input logic ertn, input logic idle, input logic sys_brk);
        mem_ctrl_t exp;
        exp.pc               = ex_in.pc;
        exp.exception_addr   = ex_in.mem_addr;
        exp.is_exception     = ex_in.is_exception;
        exp.exception_cause  = ex_in.exception_cause;
        exp.is_ertn          = ertn;
        exp.is_idle          = idle;
        exp.is_syscall_break = sys_brk;
        if (mem_ctrl != exp) begin
            stop_with_error($sformatf("FAIL mem_ctrl got %h expected %h", mem_ctrl, exp));
        end
    endtask

    always @(negedge clk) begin
        reg_write_t exp;
        if (!reset && wb_write.write_en) begin
            if (expect_q.size() == 0) begin
                stop_with_error("writeback produced a register write that no op asked for");
            end
            else begin
                exp = expect_q.pop_front();
                if (wb_write != exp) begin
                    stop_with_error($sformatf("FAIL wb_write got %h expected %h", wb_write, exp));
                end
            end
        end
    end

    always @(negedge clk) begin
        if (dut.u_props.fail_count != 0) begin
            stop_with_error("an assertion in the property checker failed");
        end
    end

    task automatic run_loads();
        aluop_t ops [6] = '{ALU_LDB, ALU_LDBU, ALU_LDH, ALU_LDHU, ALU_LDW, ALU_LLW};
        bus32_t line;
        bus32_t addr;
        int     want;
        for (int n = 0; n < 4; n++) begin
            line = next_random() & 32'hffff_fff0;
            for (int k = 0; k < 24; k++) begin
                addr = line | (next_random() & 32'h0000_000c) | 32'(k % 4);
                issue_op(make_op(ops[k / 4], addr, 5'(k + 1)), load_expect(ops[k / 4], addr));
                want = (k == 0) ? MISS_CYCLES : 0; // only the first load of a line misses.
                if (stall_cycles != want) begin
                    stop_with_error($sformatf("FAIL pause cycles got %h expected %h",
                                              stall_cycles, want));
                end
            end
        end
    endtask

    task automatic run_csr();
        csr_addr_t addrs [7] = '{CSR_CRMD, CSR_PRMD, CSR_ERA, CSR_SAVE0,
                                 CSR_SAVE1, CSR_SAVE2, CSR_SAVE3};
        bus32_t    v;
        bus32_t    d;
        bus32_t    m;
        foreach (addrs[i]) begin
            v = next_random();
            issue_op(make_csr_op(ALU_CSRWR, addrs[i], v, 32'h0), csr_model[addrs[i]]);
            csr_model[addrs[i]] = v;
            issue_op(make_csr_op(ALU_CSRRD, addrs[i], 32'h0, 32'h0), v); // forwarded.
            d = next_random();
            m = next_random();
            issue_op(make_csr_op(ALU_CSRXCHG, addrs[i], d, m), v);
            csr_model[addrs[i]] = (v & ~m) | (d & m);
            issue_op(make_op(ALU_NOP, 32'h0, 5'd0), 32'h0);
            issue_op(make_csr_op(ALU_CSRRD, addrs[i], 32'h0, 32'h0), csr_model[addrs[i]]);
        end
    endtask

    task automatic run_counters();
        issue_op(make_op(ALU_RDCNTID, 32'h0, 5'd3), csr_model[CSR_TID]);
        // the op reaches the stage one edge after it is driven.
        repeat (4) begin
            issue_op(make_op(ALU_RDCNTVLW, 32'h0, 5'd4), bus32_t'(cycle_cnt + 64'd1));
        end
        issue_op(make_op(ALU_RDCNTVHW, 32'h0, 5'd5), bus32_t'((cycle_cnt + 64'd1) >> 32));
    endtask

    task automatic run_ctrl();
        ex_mem_t e;
        issue_op(make_op(ALU_ERTN, next_random(), 5'd0), 32'h0);
        check_ctrl(1'b1, 1'b0, 1'b0);
        e = make_op(ALU_ERTN, next_random(), 5'd0);
        e.is_exception    = 6'h01;
        e.exception_cause = 6'h0d;
        issue_op(e, 32'h0);
        check_ctrl(1'b0, 1'b0, 1'b0);
        issue_op(make_op(ALU_SYSCALL, next_random(), 5'd0), 32'h0);
        check_ctrl(1'b0, 1'b0, 1'b1);
        issue_op(make_op(ALU_BREAK, next_random(), 5'd0), 32'h0);
        check_ctrl(1'b0, 1'b0, 1'b1);
        issue_op(make_op(ALU_IDLE, next_random(), 5'd0), 32'h0);
        check_ctrl(1'b0, 1'b1, 1'b0);
        e = make_op(ALU_NOP, next_random(), 5'd0);
        e.is_exception    = 6'h20;
        e.exception_cause = 6'h0b;
        issue_op(e, 32'h0);
        check_ctrl(1'b0, 1'b0, 1'b0);
    endtask

    initial begin
        int waited;
        reset        = 1'b1;
        ex_in        = '0;
        lcg_state    = 32'h4d46_18af;
        next_pc      = 32'h1c00_0000;
        stall_cycles = 0;
        csr_model[CSR_CRMD]  = '0;
        csr_model[CSR_PRMD]  = '0;
        csr_model[CSR_ERA]   = '0;
        csr_model[CSR_SAVE0] = '0;
        csr_model[CSR_SAVE1] = '0;
        csr_model[CSR_SAVE2] = '0;
        csr_model[CSR_SAVE3] = '0;
        csr_model[CSR_TID]   = TID_RESET;
        repeat (16) @(negedge clk);
        reset = 1'b0;

        run_loads();
        run_csr();
        run_counters();
        run_ctrl();
        ex_in = '0;

        waited = 0;
        while ((expect_q.size() != 0) && (waited < WAIT_LIMIT)) begin
            @(negedge clk);
            waited++;
        end
        if ((expect_q.size() == 0) && (dut.u_props.fail_count == 0)) begin
            $display("all tests passed");
            $finish;
        end
        else if (expect_q.size() != 0) begin
            stop_with_error("expected register writes never reached writeback");
        end
        else begin
            stop_with_error("an assertion in the property checker failed");
        end
    end

endmodule

`default_nettype wire
